// ==== dv/dram_bfm.sv ====
`default_nettype none

// behavioral DRAM on the external command bus
module dram_bfm (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                slow,
    input  logic                                cmd_req,
    input  logic [1:0]                          cmd,
    input  logic [dram_pkg::NUM_OF_BANKS-1:0]   bank_sel,
    input  logic [dram_pkg::ROW_W-1:0]          row_sel,
    input  logic [dram_pkg::COL_W-1:0]          col_sel,
    input  logic [dram_pkg::DATA_WIDTH-1:0]     wdata,
    output logic                                cmd_ack,
    output logic [dram_pkg::DATA_WIDTH-1:0]     rdata,
    output logic                                row_error,
    output int                                  refresh_count
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ADDR_W = dram_pkg::BANK_W + dram_pkg::ROW_W + dram_pkg::COL_W;

    logic [dram_pkg::DATA_WIDTH-1:0]   mem [2**ADDR_W];
    logic [dram_pkg::ROW_W-1:0]        open_row [dram_pkg::NUM_OF_BANKS];
    logic [dram_pkg::NUM_OF_BANKS-1:0] open_valid;
    logic                              busy;
    logic                              req_s;
    int                                delay;

    function automatic int bank_index(input logic [dram_pkg::NUM_OF_BANKS-1:0] sel);
        bank_index = 0;
        for (int i = 0; i < dram_pkg::NUM_OF_BANKS; i++) begin
            if (sel[i]) begin
                bank_index = i;
            end
        end
    endfunction

    // carries out the command at the moment ack rises
    task automatic execute_cmd();
        int                b;
        logic [ADDR_W-1:0] addr;
        b    = bank_index(bank_sel);
        addr = {dram_pkg::BANK_W'(b), row_sel, col_sel};
        case (cmd)
            dram_pkg::CMD_ACT: begin
                open_row[b]   = row_sel;
                open_valid[b] = 1'b1;
            end
            dram_pkg::CMD_REFRESH: begin
                open_valid    = '0;
                refresh_count = refresh_count + 1;
            end
            default: begin
                if (!open_valid[b] || (open_row[b] != row_sel) || !$onehot(bank_sel)) begin
                    row_error = 1'b1;
                end
                if (cmd == dram_pkg::CMD_WRITE) begin
                    mem[addr] = wdata;
                end else begin
                    rdata = mem[addr];
                end
            end
        endcase
    endtask

    initial begin
        cmd_ack       = 1'b0;
        rdata         = '0;
        row_error     = 1'b0;
        refresh_count = 0;
        open_valid    = '0;
        busy          = 1'b0;
        delay         = 0;
        for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] = '0;
        end
        forever begin
            @(posedge clk);
            req_s = cmd_req;
            #1;
            if (rst) begin
                cmd_ack    = 1'b0;
                busy       = 1'b0;
                open_valid = '0;
            end else if (cmd_ack) begin
                // release once the controller has dropped its request
                if (!req_s) begin
                    cmd_ack = 1'b0;
                end
            end else if (req_s) begin
                if (!busy) begin
                    busy  = 1'b1;
                    delay = $urandom_range(5, slow ? 4 : 2);
                end
                if (delay > 1) begin
                    delay = delay - 1;
                end else begin
                    busy = 1'b0;
                    execute_cmd();
                    cmd_ack = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/dram_ctrl_checker.sv ====
`default_nettype none

module dram_ctrl_checker (
    input logic                              clk,
    input logic                              rst,
    input logic                              l2_cmd_valid,
    input logic                              l2_req_full,
    input logic                              cmd_req,
    input logic                              cmd_ack,
    input logic [1:0]                        cmd,
    input logic [dram_pkg::NUM_OF_BANKS-1:0] bank_sel,
    input logic [dram_pkg::ROW_W-1:0]        row_sel,
    input logic [dram_pkg::COL_W-1:0]        col_sel,
    input logic [dram_pkg::DATA_WIDTH-1:0]   dram_wdata,
    input logic                              refresh_flag
);
    timeunit 1ns;
    timeprecision 100ps;

    // fields hold while a command waits for its ack
    assert property (@(posedge clk) disable iff (rst)
        (cmd_req && !cmd_ack) |=> $stable({cmd, bank_sel, row_sel, col_sel, dram_wdata}))
        else $error("command fields changed while cmd_req waited for cmd_ack");

    assert property (@(posedge clk) disable iff (rst) $rose(cmd_req) |-> !cmd_ack)
        else $error("cmd_req rose while cmd_ack was still high");

    assert property (@(posedge clk) disable iff (rst) refresh_flag |=> !refresh_flag)
        else $error("refresh_flag stayed high for more than one cycle");

    // L2 side back-pressure
    assert property (@(posedge clk) disable iff (rst) l2_req_full |-> !l2_cmd_valid)
        else $error("l2_cmd_valid was strobed while l2_req_full was high");

endmodule

bind dram_ctrl_top dram_ctrl_checker i_dram_ctrl_checker (
    .clk          (clk),
    .rst          (rst),
    .l2_cmd_valid (l2_cmd_valid),
    .l2_req_full  (l2_req_full),
    .cmd_req      (cmd_req),
    .cmd_ack      (cmd_ack),
    .cmd          (cmd),
    .bank_sel     (bank_sel),
    .row_sel      (row_sel),
    .col_sel      (col_sel),
    .dram_wdata   (dram_wdata),
    .refresh_flag (refresh_flag)
);

`default_nettype wire

// ==== dv/dram_ctrl_tb.sv ====
`default_nettype none

module dram_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD       = 4;
    localparam int RESET_CYCLES     = 16;
    localparam int BUF_DEPTH        = 16;
    localparam int REFRESH_INTERVAL = 64;
    localparam int NUM_REQS         = 300;
    localparam int CYCLES_PER_REQ   = 200;
    // generous bound on one handshake, grant to done
    localparam int MAX_CMD_CYCLES   = 16;
    localparam int INSTR_W          = dram_pkg::L2_REQ_WIDTH;
    localparam int DATA_W           = dram_pkg::DATA_WIDTH;
    localparam int ADDR_W           = dram_pkg::BANK_W + dram_pkg::ROW_W + dram_pkg::COL_W;

    logic                              clk = 1'b0;
    logic                              rst;
    logic                              l2_cmd_valid;
    logic                              l2_rw_req;
    logic [INSTR_W-1:0]                l2_req_instr;
    logic [DATA_W-1:0]                 l2_req_data;
    logic                              l2_req_full;
    logic                              l2_rsp_valid;
    logic [DATA_W-1:0]                 l2_rsp_data;
    logic                              cmd_req;
    logic [1:0]                        cmd;
    logic [dram_pkg::NUM_OF_BANKS-1:0] bank_sel;
    logic [dram_pkg::ROW_W-1:0]        row_sel;
    logic [dram_pkg::COL_W-1:0]        col_sel;
    logic [DATA_W-1:0]                 dram_wdata;
    logic                              cmd_ack;
    logic [DATA_W-1:0]                 dram_rdata;
    logic                              slow;
    logic                              row_error;
    int                                bfm_refreshes;

    logic [DATA_W-1:0]  ref_mem [logic [ADDR_W-1:0]];
    logic [DATA_W-1:0]  expected_q [$];
    logic [INSTR_W-1:0] wr_addrs [64];
    int                 reads_issued = 0;
    int                 resp_count = 0;
    int                 refresh_pulses = 0;
    int                 refresh_gap = 0;
    logic               full_seen = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    dram_ctrl_top #(
        .BUF_DEPTH        (BUF_DEPTH),
        .REFRESH_INTERVAL (REFRESH_INTERVAL)
    ) i_dram_ctrl_top (
        .clk          (clk),
        .rst          (rst),
        .l2_cmd_valid (l2_cmd_valid),
        .l2_rw_req    (l2_rw_req),
        .l2_req_instr (l2_req_instr),
        .l2_req_data  (l2_req_data),
        .l2_req_full  (l2_req_full),
        .l2_rsp_valid (l2_rsp_valid),
        .l2_rsp_data  (l2_rsp_data),
        .cmd_req      (cmd_req),
        .cmd          (cmd),
        .bank_sel     (bank_sel),
        .row_sel      (row_sel),
        .col_sel      (col_sel),
        .dram_wdata   (dram_wdata),
        .cmd_ack      (cmd_ack),
        .dram_rdata   (dram_rdata)
    );

    dram_bfm i_dram_bfm (
        .clk           (clk),
        .rst           (rst),
        .slow          (slow),
        .cmd_req       (cmd_req),
        .cmd           (cmd),
        .bank_sel      (bank_sel),
        .row_sel       (row_sel),
        .col_sel       (col_sel),
        .wdata         (dram_wdata),
        .cmd_ack       (cmd_ack),
        .rdata         (dram_rdata),
        .row_error     (row_error),
        .refresh_count (bfm_refreshes)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR: time %0t signal %s actual 0x%0h expected 0x%0h",
                                $time, name, actual, expected));
        end
    endtask

    // bank, row and column as one flat DRAM address
    function automatic logic [ADDR_W-1:0] dram_addr(input logic [INSTR_W-1:0] instr);
        dram_addr = {instr[dram_pkg::BANK_MSB:dram_pkg::BANK_LSB],
                     instr[dram_pkg::ROW_MSB:dram_pkg::ROW_LSB],
                     instr[dram_pkg::COL_MSB:dram_pkg::COL_LSB]};
    endfunction

    // unwritten locations read as zero
    function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
        if (ref_mem.exists(addr)) begin
            expected_read = ref_mem[addr];
        end else begin
            expected_read = '0;
        end
    endfunction

    function automatic logic [INSTR_W-1:0] random_instr();
        random_instr = INSTR_W'($urandom());
    endfunction

    // called 1 ns after a rising edge, returns at the same point of a later cycle
    task automatic send_req(input logic rw, input logic [INSTR_W-1:0] instr,
                            input logic [DATA_W-1:0] data);
        while (l2_req_full) begin
            full_seen = 1'b1;
            @(posedge clk);
            #1;
        end
        l2_cmd_valid = 1'b1;
        l2_rw_req    = rw;
        l2_req_instr = instr;
        l2_req_data  = data;
        if (rw) begin
            ref_mem[dram_addr(instr)] = data;
        end else begin
            expected_q.push_back(expected_read(dram_addr(instr)));
            reads_issued = reads_issued + 1;
        end
        @(posedge clk);
        #1;
        l2_cmd_valid = 1'b0;
    endtask

    task automatic wait_responses();
        while (resp_count != reads_issued) begin
            @(posedge clk);
            #1;
        end
    endtask

    always @(posedge clk) begin
        if (!rst && l2_rsp_valid) begin
            if (expected_q.size() == 0) begin
                abort_run("a read response arrived with no read pending");
            end else begin
                check_value("l2_rsp_data", l2_rsp_data, expected_q.pop_front());
                resp_count <= resp_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (row_error) begin
            abort_run("the DRAM model saw a read or write to a row that was not open");
        end
    end

    // refreshes must keep coming at the interval plus bus contention
    always @(posedge clk) begin
        if (rst) begin
            refresh_gap <= 0;
        end else if (i_dram_ctrl_top.refresh_flag) begin
            refresh_gap    <= 0;
            refresh_pulses <= refresh_pulses + 1;
        end else if (refresh_gap > REFRESH_INTERVAL + 2 * MAX_CMD_CYCLES) begin
            abort_run("no refresh was issued within the refresh interval");
        end else begin
            refresh_gap <= refresh_gap + 1;
        end
    end

    initial begin
        #(NUM_REQS * CYCLES_PER_REQ * CLK_PERIOD);
        abort_run("watchdog timeout, the request stream did not complete in time");
    end

    initial begin
        logic [INSTR_W-1:0] base;
        rst          = 1'b1;
        l2_cmd_valid = 1'b0;
        l2_rw_req    = 1'b0;
        l2_req_instr = '0;
        l2_req_data  = '0;
        slow         = 1'b0;
        void'($urandom(85));
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        // reset leaves the bus idle, the buffer empty and no response pending
        check_value("cmd_req", cmd_req, 0);
        check_value("l2_rsp_valid", l2_rsp_valid, 0);
        check_value("l2_req_full", l2_req_full, 0);

        // nothing written yet, so these read back zero
        for (int i = 0; i < 8; i++) begin
            send_req(1'b0, random_instr(), '0);
        end

        for (int i = 0; i < 64; i++) begin
            wr_addrs[i] = random_instr();
            send_req(1'b1, wr_addrs[i], DATA_W'($urandom()));
        end
        for (int i = 0; i < 64; i++) begin
            send_req(1'b0, wr_addrs[i], '0);
        end
        wait_responses();

        // incrementing runs with random bank and row jumps between them
        for (int r = 0; r < 8; r++) begin
            base = random_instr();
            for (int k = 0; k < 12; k++) begin
                send_req(1'($urandom_range(1, 0)), base + INSTR_W'(k), DATA_W'($urandom()));
            end
        end
        wait_responses();

        // slow acks so the request buffer fills
        slow      = 1'b1;
        full_seen = 1'b0;
        for (int i = 0; i < 48; i++) begin
            send_req(1'($urandom_range(1, 0)), random_instr(), DATA_W'($urandom()));
        end
        wait_responses();
        slow = 1'b0;
        if (!full_seen) begin
            abort_run("the request buffer never filled during the slow burst");
        end

        // let the last handshake finish before counting refreshes
        while (cmd_req || cmd_ack) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        check_value("refresh_count", refresh_pulses, bfm_refreshes);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# builds the DRAM controller testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module dram_ctrl_tb -f vlog.f -o dram_ctrl_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/dram_ctrl_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// ==== src/access_engine.sv ====
`default_nettype none

module access_engine (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              buf_empty,
    input  logic                              head_rw,
    input  logic [dram_pkg::L2_REQ_WIDTH-1:0] head_instr,
    input  logic [dram_pkg::DATA_WIDTH-1:0]   head_data,
    input  logic                              rows_closed,
    output logic                              buf_pop,
    dram_cmd_if.requester                     bus,
    output logic                              rsp_valid,
    output logic [dram_pkg::DATA_WIDTH-1:0]   rsp_data
);

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_ACTIVATE = 2'd1;
    localparam logic [1:0] ST_ACCESS   = 2'd2;
    localparam logic [1:0] ST_RESPOND  = 2'd3;

    logic [1:0]                      state;
    logic                            cur_rw;
    logic [dram_pkg::BANK_W-1:0]     cur_bank;
    logic [dram_pkg::ROW_W-1:0]      cur_row;
    logic [dram_pkg::COL_W-1:0]      cur_col;
    logic [dram_pkg::DATA_WIDTH-1:0] cur_wdata;
    logic [dram_pkg::BANK_W-1:0]     head_bank;
    logic [dram_pkg::ROW_W-1:0]      head_row;
    logic                            row_hit;

    // open row per bank, valid bit says the bank is active
    logic [dram_pkg::ROW_W-1:0]        open_row [dram_pkg::NUM_OF_BANKS];
    logic [dram_pkg::NUM_OF_BANKS-1:0] open_valid;

    assign head_bank = head_instr[dram_pkg::BANK_MSB:dram_pkg::BANK_LSB];
    assign head_row  = head_instr[dram_pkg::ROW_MSB:dram_pkg::ROW_LSB];

    // a refresh landing this cycle closes the row even though valid is still set
    assign row_hit = open_valid[head_bank] && !rows_closed && (open_row[head_bank] == head_row);

    assign buf_pop   = (state == ST_IDLE) && !buf_empty;
    assign rsp_valid = (state == ST_RESPOND);

    assign bus.req     = (state == ST_ACTIVATE) || (state == ST_ACCESS);
    assign bus.cmd     = (state == ST_ACTIVATE) ? dram_pkg::CMD_ACT :
                         cur_rw ? dram_pkg::CMD_WRITE : dram_pkg::CMD_READ;
    assign bus.bank_id = cur_bank;
    assign bus.row_id  = cur_row;
    assign bus.col_id  = cur_col;
    assign bus.wdata   = cur_wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            open_valid <= '0;
        end else begin
            if (rows_closed) begin
                open_valid <= '0;
            end
            case (state)
                ST_IDLE: begin
                    if (!buf_empty) begin
                        state <= row_hit ? ST_ACCESS : ST_ACTIVATE;
                    end
                end
                ST_ACTIVATE: begin
                    if (bus.done) begin
                        open_valid[cur_bank] <= 1'b1;
                        state                <= ST_ACCESS;
                    end
                end
                ST_ACCESS: begin
                    if (bus.done) begin
                        state <= cur_rw ? ST_IDLE : ST_RESPOND;
                    end else if (rows_closed) begin
                        // refresh won the bus first and closed our row, reopen it
                        state <= ST_ACTIVATE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (buf_pop) begin
            cur_rw    <= head_rw;
            cur_bank  <= head_bank;
            cur_row   <= head_row;
            cur_col   <= head_instr[dram_pkg::COL_MSB:dram_pkg::COL_LSB];
            cur_wdata <= head_data;
        end
        if ((state == ST_ACTIVATE) && bus.done) begin
            open_row[cur_bank] <= cur_row;
        end
        if ((state == ST_ACCESS) && bus.done && !cur_rw) begin
            rsp_data <= bus.rdata;
        end
    end

endmodule

`default_nettype wire

// ==== src/cmd_arbiter.sv ====
`default_nettype none

module cmd_arbiter (
    input  logic                                clk,
    input  logic                                rst,
    dram_cmd_if.arbiter                         acc,
    dram_cmd_if.arbiter                         rfsh,
    output logic                                cmd_req,
    output logic [1:0]                          cmd,
    output logic [dram_pkg::NUM_OF_BANKS-1:0]   bank_sel,
    output logic [dram_pkg::ROW_W-1:0]          row_sel,
    output logic [dram_pkg::COL_W-1:0]          col_sel,
    output logic [dram_pkg::DATA_WIDTH-1:0]     dram_wdata,
    input  logic                                cmd_ack,
    input  logic [dram_pkg::DATA_WIDTH-1:0]     dram_rdata
);

    localparam logic [1:0] ST_IDLE         = 2'd0;
    localparam logic [1:0] ST_WAIT_ACK     = 2'd1;
    localparam logic [1:0] ST_WAIT_RELEASE = 2'd2;

    localparam logic [dram_pkg::NUM_OF_BANKS-1:0] BANK_ONE = 1;

    logic [1:0]                      state;
    logic                            owner_ref;
    logic                            done;
    logic [dram_pkg::DATA_WIDTH-1:0] rdata_q;
    logic [1:0]                      sel_cmd;
    logic [dram_pkg::BANK_W-1:0]     sel_bank;
    logic [dram_pkg::ROW_W-1:0]      sel_row;
    logic [dram_pkg::COL_W-1:0]      sel_col;
    logic [dram_pkg::DATA_WIDTH-1:0] sel_wdata;

    // refresh has priority at every grant decision
    assign sel_cmd   = rfsh.req ? rfsh.cmd     : acc.cmd;
    assign sel_bank  = rfsh.req ? rfsh.bank_id : acc.bank_id;
    assign sel_row   = rfsh.req ? rfsh.row_id  : acc.row_id;
    assign sel_col   = rfsh.req ? rfsh.col_id  : acc.col_id;
    assign sel_wdata = rfsh.req ? rfsh.wdata   : acc.wdata;

    // handshake ends once ack is seen low again
    assign done = (state == ST_WAIT_RELEASE) && !cmd_ack;

    assign acc.done   = done && !owner_ref;
    assign rfsh.done  = done && owner_ref;
    assign acc.rdata  = owner_ref ? '0 : rdata_q;
    assign rfsh.rdata = owner_ref ? rdata_q : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            cmd_req   <= 1'b0;
            owner_ref <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (rfsh.req || acc.req) begin
                        owner_ref <= rfsh.req;
                        cmd_req   <= 1'b1;
                        state     <= ST_WAIT_ACK;
                    end
                end
                ST_WAIT_ACK: begin
                    if (cmd_ack) begin
                        cmd_req <= 1'b0;
                        state   <= ST_WAIT_RELEASE;
                    end
                end
                ST_WAIT_RELEASE: begin
                    if (!cmd_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && (rfsh.req || acc.req)) begin
            cmd        <= sel_cmd;
            bank_sel   <= BANK_ONE << sel_bank;
            row_sel    <= sel_row;
            col_sel    <= sel_col;
            dram_wdata <= sel_wdata;
        end
        // read data is only valid while ack is high
        if ((state == ST_WAIT_ACK) && cmd_ack) begin
            rdata_q <= dram_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== src/dram_cmd_if.sv ====
`default_nettype none

// one requester's command path into the arbiter
interface dram_cmd_if;

    logic                              req;
    logic [1:0]                        cmd;
    logic [dram_pkg::BANK_W-1:0]       bank_id;
    logic [dram_pkg::ROW_W-1:0]        row_id;
    logic [dram_pkg::COL_W-1:0]        col_id;
    logic [dram_pkg::DATA_WIDTH-1:0]   wdata;
    // done pulses once when the command has completed on the bus
    logic                              done;
    logic [dram_pkg::DATA_WIDTH-1:0]   rdata;

    modport requester (
        output req, cmd, bank_id, row_id, col_id, wdata,
        input  done, rdata
    );

    modport arbiter (
        input  req, cmd, bank_id, row_id, col_id, wdata,
        output done, rdata
    );

endinterface

`default_nettype wire

// ==== src/dram_ctrl_top.sv ====
`default_nettype none

module dram_ctrl_top #(
    parameter int BUF_DEPTH        = dram_pkg::DEF_BUF_DEPTH,
    parameter int REFRESH_INTERVAL = dram_pkg::DEF_REFRESH_INTERVAL
) (
    input  logic                                clk,
    input  logic                                rst,
    // L2 side
    input  logic                                l2_cmd_valid,
    input  logic                                l2_rw_req,
    input  logic [dram_pkg::L2_REQ_WIDTH-1:0]   l2_req_instr,
    input  logic [dram_pkg::DATA_WIDTH-1:0]     l2_req_data,
    output logic                                l2_req_full,
    output logic                                l2_rsp_valid,
    output logic [dram_pkg::DATA_WIDTH-1:0]     l2_rsp_data,
    // DRAM command bus, row and column go out as binary ids
    output logic                                cmd_req,
    output logic [1:0]                          cmd,
    output logic [dram_pkg::NUM_OF_BANKS-1:0]   bank_sel,
    output logic [dram_pkg::ROW_W-1:0]          row_sel,
    output logic [dram_pkg::COL_W-1:0]          col_sel,
    output logic [dram_pkg::DATA_WIDTH-1:0]     dram_wdata,
    input  logic                                cmd_ack,
    input  logic [dram_pkg::DATA_WIDTH-1:0]     dram_rdata
);

    logic                              buf_empty;
    logic                              buf_pop;
    logic                              head_rw;
    logic [dram_pkg::L2_REQ_WIDTH-1:0] head_instr;
    logic [dram_pkg::DATA_WIDTH-1:0]   head_data;
    logic                              rows_closed;
    logic                              refresh_flag;

    dram_cmd_if acc_bus ();
    dram_cmd_if ref_bus ();

    l2_req_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) i_l2_req_buffer (
        .clk        (clk),
        .rst        (rst),
        .push       (l2_cmd_valid),
        .push_rw    (l2_rw_req),
        .push_instr (l2_req_instr),
        .push_data  (l2_req_data),
        .pop        (buf_pop),
        .empty      (buf_empty),
        .full       (l2_req_full),
        .head_rw    (head_rw),
        .head_instr (head_instr),
        .head_data  (head_data)
    );

    access_engine i_access_engine (
        .clk         (clk),
        .rst         (rst),
        .buf_empty   (buf_empty),
        .head_rw     (head_rw),
        .head_instr  (head_instr),
        .head_data   (head_data),
        .rows_closed (rows_closed),
        .buf_pop     (buf_pop),
        .bus         (acc_bus.requester),
        .rsp_valid   (l2_rsp_valid),
        .rsp_data    (l2_rsp_data)
    );

    refresh_engine #(
        .REFRESH_INTERVAL (REFRESH_INTERVAL)
    ) i_refresh_engine (
        .clk          (clk),
        .rst          (rst),
        .bus          (ref_bus.requester),
        .refresh_flag (refresh_flag),
        .rows_closed  (rows_closed)
    );

    cmd_arbiter i_cmd_arbiter (
        .clk        (clk),
        .rst        (rst),
        .acc        (acc_bus.arbiter),
        .rfsh       (ref_bus.arbiter),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .bank_sel   (bank_sel),
        .row_sel    (row_sel),
        .col_sel    (col_sel),
        .dram_wdata (dram_wdata),
        .cmd_ack    (cmd_ack),
        .dram_rdata (dram_rdata)
    );

endmodule

`default_nettype wire

// ==== src/dram_pkg.sv ====
`default_nettype none

package dram_pkg;

    // request word and data widths on the L2 side
    parameter int L2_REQ_WIDTH = 20;
    parameter int DATA_WIDTH   = 8;

    // instruction word layout, the offset field is carried but never decoded
    parameter int OFFSET_MSB = 19;
    parameter int OFFSET_LSB = 13;
    parameter int BANK_MSB   = 12;
    parameter int BANK_LSB   = 10;
    parameter int ROW_MSB    = 9;
    parameter int ROW_LSB    = 3;
    parameter int COL_MSB    = 2;
    parameter int COL_LSB    = 0;

    // array geometry and the id widths that follow from it
    parameter int NUM_OF_BANKS = 8;
    parameter int NUM_OF_ROWS  = 128;
    parameter int NUM_OF_COLS  = 8;
    parameter int BANK_W       = $clog2(NUM_OF_BANKS);
    parameter int ROW_W        = $clog2(NUM_OF_ROWS);
    parameter int COL_W        = $clog2(NUM_OF_COLS);

    // command codes on the DRAM bus
    parameter logic [1:0] CMD_ACT     = 2'd0;
    parameter logic [1:0] CMD_READ    = 2'd1;
    parameter logic [1:0] CMD_WRITE   = 2'd2;
    parameter logic [1:0] CMD_REFRESH = 2'd3;

    // default sizes, overridden from the top level
    parameter int DEF_BUF_DEPTH        = 16;
    parameter int DEF_REFRESH_INTERVAL = 256;

endpackage

`default_nettype wire

// ==== src/l2_req_buffer.sv ====
`default_nettype none

module l2_req_buffer #(
    parameter int BUF_DEPTH = dram_pkg::DEF_BUF_DEPTH
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              push,
    input  logic                              push_rw,
    input  logic [dram_pkg::L2_REQ_WIDTH-1:0] push_instr,
    input  logic [dram_pkg::DATA_WIDTH-1:0]   push_data,
    input  logic                              pop,
    output logic                              empty,
    output logic                              full,
    output logic                              head_rw,
    output logic [dram_pkg::L2_REQ_WIDTH-1:0] head_instr,
    output logic [dram_pkg::DATA_WIDTH-1:0]   head_data
);

    localparam int PTR_W   = $clog2(BUF_DEPTH);
    localparam int CNT_W   = $clog2(BUF_DEPTH + 1);
    localparam int ENTRY_W = 1 + dram_pkg::L2_REQ_WIDTH + dram_pkg::DATA_WIDTH;

    logic [ENTRY_W-1:0] mem [BUF_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_push;
    logic               do_pop;

    // depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        next_ptr = (ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(BUF_DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign {head_rw, head_instr, head_data} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= {push_rw, push_instr, push_data};
        end
    end

endmodule

`default_nettype wire

// ==== src/refresh_engine.sv ====
`default_nettype none

module refresh_engine #(
    parameter int REFRESH_INTERVAL = dram_pkg::DEF_REFRESH_INTERVAL
) (
    input  logic          clk,
    input  logic          rst,
    dram_cmd_if.requester bus,
    output logic          refresh_flag,
    output logic          rows_closed
);

    localparam int CNT_W = $clog2(REFRESH_INTERVAL + 1);

    logic [CNT_W-1:0] cnt;

    // counter parks at the interval and holds req until the refresh is done
    assign bus.req     = (cnt == CNT_W'(REFRESH_INTERVAL));
    assign bus.cmd     = dram_pkg::CMD_REFRESH;
    assign bus.bank_id = '0;
    assign bus.row_id  = '0;
    assign bus.col_id  = '0;
    assign bus.wdata   = '0;

    // a refresh closes every bank
    assign refresh_flag = bus.done;
    assign rows_closed  = bus.done;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (bus.done) begin
            cnt <= '0;
        end else if (!bus.req) begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/dram_pkg.sv
src/dram_cmd_if.sv
src/l2_req_buffer.sv
src/access_engine.sv
src/refresh_engine.sv
src/cmd_arbiter.sv
src/dram_ctrl_top.sv
dv/dram_bfm.sv
dv/dram_ctrl_checker.sv
dv/dram_ctrl_tb.sv
